//--- raster_defines.svh
//////////////////////////////////////////////////
// Rasterizer widths and counts shared project-wide
//////////////////////////////////////////////////
`ifndef RASTER_DEFINES_SVH
`define RASTER_DEFINES_SVH

// Bits in a fixed-point coordinate or colour value
`define RASTER_SIGFIG 24
// Fraction bits of a coordinate
`define RASTER_RADIX  10
// Vertices per triangle
`define RASTER_VERTS  3
// Axes per vertex, x y z
`define RASTER_AXIS   3
// Colour channels
`define RASTER_COLORS 3

`endif

//--- source/raster_pkg.sv
//////////////////////////////////////////////////
// Rasterizer types for the sample iterator
//////////////////////////////////////////////////
`default_nettype none

`include "raster_defines.svh"

package raster_pkg;

    // Signed fixed point, low RASTER_RADIX bits are fraction
    typedef logic signed [`RASTER_SIGFIG-1:0] coord_t;

    // Unsigned colour channel value
    typedef logic [`RASTER_SIGFIG-1:0] color_t;

    // One-hot subsample width
    // 1000 is 1x, 0100 is 4x, 0010 is 16x, 0001 is 64x MSAA
    typedef logic [3:0] subsample_t;

    // Iterator FSM states
    typedef enum logic {
        WAIT_STATE,
        TEST_STATE
    } iter_state_t;

endpackage

`default_nettype wire

//--- source/sample_walker.sv
//////////////////////////////////////////////////
// Sample walker for the bounding-box iterator
// Steps left to right, bottom to top over the box
//////////////////////////////////////////////////
`default_nettype none

`include "raster_defines.svh"

module sample_walker
    import raster_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    // Box to walk indexed by corner then axis
    input  coord_t     box_in [1:0][1:0],
    input  subsample_t subsample,
    // Capture a new box
    input  logic       load,
    // Advance one sample
    input  logic       step,
    // Current sample indexed by axis
    output coord_t     sample [1:0],
    // Current sample is the last of the box
    output logic       at_end
);

    // Box held for the current walk
    coord_t box_q [1:0][1:0];

    // Subsample code held for the current walk
    subsample_t sub_q;

    // Distance between neighbouring samples on either axis
    coord_t samp_step;

    // Position of the current sample against the box maxima
    logic at_right;
    logic at_top;

    // Code 1000 lands on the integer bit, code 0001 on an eighth
    assign samp_step = coord_t'(sub_q) << (`RASTER_RADIX - 3);

    // Maxima are inclusive
    assign at_right = (sample[0] >= box_q[1][0]);
    assign at_top   = (sample[1] >= box_q[1][1]);

    // Top-right sample ends the walk
    assign at_end = at_right && at_top;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            box_q  <= '{default: '0};
            sub_q  <= '0;
            sample <= '{default: '0};
        end else if (load) begin
            // New box, start at its lower-left corner
            box_q     <= box_in;
            sub_q     <= subsample;
            sample[0] <= box_in[0][0];
            sample[1] <= box_in[0][1];
        end else if (step) begin
            if (at_end) begin
                // Park on lower-left once the box is done
                sample[0] <= box_q[0][0];
                sample[1] <= box_q[0][1];
            end else if (at_right) begin
                // Wrap to min x, one row up
                sample[0] <= box_q[0][0];
                sample[1] <= sample[1] + samp_step;
            end else begin
                // Next column on the same row
                sample[0] <= sample[0] + samp_step;
            end
        end
    end

    // While the controller walks, every sample sits on or above the box minimum
    assert property (@(posedge clk) disable iff (rst)
        step |-> (sample[0] >= box_q[0][0]) && (sample[1] >= box_q[0][1]));

    // and never past the box maximum, which needs a grid-aligned box
    assert property (@(posedge clk) disable iff (rst)
        step |-> (sample[0] <= box_q[1][0]) && (sample[1] <= box_q[1][1]));

endmodule

`default_nettype wire

//--- source/iter_control.sv
//////////////////////////////////////////////////
// Iterator FSM, waiting or testing
// Holds the triangle and drives sample valid and halt
//////////////////////////////////////////////////
`default_nettype none

`include "raster_defines.svh"

module iter_control
    import raster_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    // Triangle and colour from the stage above
    input  coord_t tri_in [`RASTER_VERTS-1:0][`RASTER_AXIS-1:0],
    input  color_t color_in [`RASTER_COLORS-1:0],
    input  logic   tri_valid,
    // Walker has reached the top-right sample
    input  logic   at_end,
    // Walker controls
    output logic   load,
    output logic   step,
    // Triangle and colour held for the walk
    output coord_t tri_out [`RASTER_VERTS-1:0][`RASTER_AXIS-1:0],
    output color_t color_out [`RASTER_COLORS-1:0],
    output logic   sample_valid,
    // Low while walking, stalls the stage above
    output logic   halt_n
);

    iter_state_t state;
    iter_state_t next_state;

    // Accept only while waiting
    assign load = (state == WAIT_STATE) && tri_valid;

    // Walker advances every testing cycle
    assign step = (state == TEST_STATE);

    always_comb begin
        next_state = state;
        case (state)
            WAIT_STATE: begin
                if (tri_valid) begin
                    next_state = TEST_STATE;
                end
            end
            TEST_STATE: begin
                // Last sample goes out this cycle
                if (at_end) begin
                    next_state = WAIT_STATE;
                end
            end
            default: begin
                next_state = WAIT_STATE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= WAIT_STATE;
            sample_valid <= 1'b0;
            halt_n       <= 1'b1;
            tri_out      <= '{default: '0};
            color_out    <= '{default: '0};
        end else begin
            state <= next_state;

            // Moore outputs follow the state being entered
            sample_valid <= (next_state == TEST_STATE);
            halt_n       <= (next_state != TEST_STATE);

            // Inputs may change under halt, so grab them once
            if (load) begin
                tri_out   <= tri_in;
                color_out <= color_in;
            end
        end
    end

    // Valid triangle while waiting starts a walk
    assert property (@(posedge clk) disable iff (rst)
        (state == WAIT_STATE) && tri_valid |=> (state == TEST_STATE));

    // Last sample ends the walk
    assert property (@(posedge clk) disable iff (rst)
        (state == TEST_STATE) && at_end |=> (state == WAIT_STATE));

    // Idle input keeps us waiting
    assert property (@(posedge clk) disable iff (rst)
        (state == WAIT_STATE) && !tri_valid |=> (state == WAIT_STATE));

    // Mid-box keeps us testing
    assert property (@(posedge clk) disable iff (rst)
        (state == TEST_STATE) && !at_end |=> (state == TEST_STATE));

    // Stage above is held exactly while samples go out
    assert property (@(posedge clk) disable iff (rst)
        sample_valid == !halt_n);

endmodule

`default_nettype wire

//--- source/bbox_sample_iterator.sv
//////////////////////////////////////////////////
// Bounding-box sample iterator top level
//////////////////////////////////////////////////
`default_nettype none

`include "raster_defines.svh"

module bbox_sample_iterator
    import raster_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    // Triangle, colour and box from the stage above
    input  coord_t     tri_in [`RASTER_VERTS-1:0][`RASTER_AXIS-1:0],
    input  color_t     color_in [`RASTER_COLORS-1:0],
    input  coord_t     box_in [1:0][1:0],
    input  logic       tri_valid,
    input  subsample_t subsample,
    // Towards the sample test
    output coord_t     tri_out [`RASTER_VERTS-1:0][`RASTER_AXIS-1:0],
    output color_t     color_out [`RASTER_COLORS-1:0],
    output coord_t     sample [1:0],
    output logic       sample_valid,
    // Active-low stall of the stage above
    output logic       halt_n
);

    // Controller to walker
    logic load;
    logic step;
    // Walker to controller
    logic at_end;

    iter_control iter_control_i (
        .clk          (clk),
        .rst          (rst),
        .tri_in       (tri_in),
        .color_in     (color_in),
        .tri_valid    (tri_valid),
        .at_end       (at_end),
        .load         (load),
        .step         (step),
        .tri_out      (tri_out),
        .color_out    (color_out),
        .sample_valid (sample_valid),
        .halt_n       (halt_n)
    );

    sample_walker sample_walker_i (
        .clk       (clk),
        .rst       (rst),
        .box_in    (box_in),
        .subsample (subsample),
        .load      (load),
        .step      (step),
        .sample    (sample),
        .at_end    (at_end)
    );

endmodule

`default_nettype wire

//--- test/tb_bbox_sample_iterator.sv
//////////////////////////////////////////////////
// Testbench for the bounding-box sample iterator
// Table-driven walks checked against a reference walk model
//////////////////////////////////////////////////
`default_nettype none

`include "raster_defines.svh"

module tb_bbox_sample_iterator
    import raster_pkg::*;
();

    localparam int NUM_ENTRIES  = 7;
    localparam int RESET_CYCLES = 5;
    localparam int MARGIN       = 20;
    // Cycles to wait for a walk to start after tri_valid
    localparam int ACCEPT_WAIT  = 8;

    logic       clk;
    logic       rst;
    coord_t     tri_in [`RASTER_VERTS-1:0][`RASTER_AXIS-1:0];
    color_t     color_in [`RASTER_COLORS-1:0];
    coord_t     box_in [1:0][1:0];
    logic       tri_valid;
    subsample_t subsample;
    coord_t     tri_out [`RASTER_VERTS-1:0][`RASTER_AXIS-1:0];
    color_t     color_out [`RASTER_COLORS-1:0];
    coord_t     sample [1:0];
    logic       sample_valid;
    logic       halt_n;

    // Stimulus table with box corners in eighths of a pixel
    subsample_t tab_code [NUM_ENTRIES];
    int         tab_min_x [NUM_ENTRIES];
    int         tab_min_y [NUM_ENTRIES];
    int         tab_max_x [NUM_ENTRIES];
    int         tab_max_y [NUM_ENTRIES];
    // Idle cycles before the entry where a negative value draws a random gap
    int         tab_gap [NUM_ENTRIES];

    // Expected walk of the current entry
    coord_t exp_x [$];
    coord_t exp_y [$];
    coord_t exp_tri [`RASTER_VERTS-1:0][`RASTER_AXIS-1:0];
    color_t exp_color [`RASTER_COLORS-1:0];

    int errors = 0;
    int cycles = 0;
    int limit;

    bbox_sample_iterator bbox_sample_iterator_i (
        .clk          (clk),
        .rst          (rst),
        .tri_in       (tri_in),
        .color_in     (color_in),
        .box_in       (box_in),
        .tri_valid    (tri_valid),
        .subsample    (subsample),
        .tri_out      (tri_out),
        .color_out    (color_out),
        .sample       (sample),
        .sample_valid (sample_valid),
        .halt_n       (halt_n)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Run limit sized from the table
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    task automatic coord_check(input string name, input coord_t got, input coord_t want);
        if (got !== want) begin
            errors++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, want);
        end
    endtask

    task automatic color_check(input string name, input color_t got, input color_t want);
        if (got !== want) begin
            errors++;
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, want);
        end
    endtask

    task automatic level_check(input string name, input logic got, input logic want);
        if (got !== want) begin
            errors++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, want);
        end
    endtask

    task automatic count_check(input string name, input int got, input int want);
        if (got != want) begin
            errors++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, want);
        end
    endtask

    // Eighths of a pixel to fixed point
    function automatic coord_t to_coord(input int eighths);
        return coord_t'(eighths * (1 << (`RASTER_RADIX - 3)));
    endfunction

    task automatic add_entry(input int i, input subsample_t code, input int min_x,
                             input int min_y, input int max_x, input int max_y,
                             input int gap);
        tab_code[i]  = code;
        tab_min_x[i] = min_x;
        tab_min_y[i] = min_y;
        tab_max_x[i] = max_x;
        tab_max_y[i] = max_y;
        tab_gap[i]   = gap;
    endtask

    // All four codes plus a one-sample box, negative corners and zero gaps
    task automatic load_table;
        add_entry(0, 4'b1000,  16,   8,  40,  24,  3);
        add_entry(1, 4'b0100, -12,   4,  -4,   8,  0);
        add_entry(2, 4'b0010,   6,  -6,   6,  -6,  0);
        add_entry(3, 4'b0001, 100,  50, 101,  52,  2);
        add_entry(4, 4'b1000, -40, -40, -40, -24, -1);
        add_entry(5, 4'b0001,   0,   0,   3,   0,  0);
        add_entry(6, 4'b0100,  20,  20,  24,  28, -1);
    endtask

    // Resolve random gaps, then size the run from rows times columns
    task automatic timeout_from_table;
        int cols;
        int rows;
        limit = RESET_CYCLES + MARGIN;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (tab_gap[i] < 0) begin
                tab_gap[i] = int'($urandom % 4) + 1;
            end
            // Step in eighths equals the code's value
            cols = (tab_max_x[i] - tab_min_x[i]) / int'(tab_code[i]) + 1;
            rows = (tab_max_y[i] - tab_min_y[i]) / int'(tab_code[i]) + 1;
            limit += cols * rows + tab_gap[i] + 4;
        end
    endtask

    // Reference walk from left to right, then bottom to top
    task automatic walk_order(input int i);
        int step8;
        exp_x.delete();
        exp_y.delete();
        step8 = int'(tab_code[i]);
        for (int y = tab_min_y[i]; y <= tab_max_y[i]; y += step8) begin
            for (int x = tab_min_x[i]; x <= tab_max_x[i]; x += step8) begin
                exp_x.push_back(to_coord(x));
                exp_y.push_back(to_coord(y));
            end
        end
    endtask

    task automatic fresh_inputs;
        for (int v = 0; v < `RASTER_VERTS; v++) begin
            for (int a = 0; a < `RASTER_AXIS; a++) begin
                tri_in[v][a] = coord_t'($urandom);
            end
        end
        for (int c = 0; c < `RASTER_COLORS; c++) begin
            color_in[c] = color_t'($urandom);
        end
    endtask

    // Box and code that the walker must ignore while testing
    task automatic disturb_box;
        for (int c = 0; c < 2; c++) begin
            for (int a = 0; a < 2; a++) begin
                box_in[c][a] = coord_t'($urandom);
            end
        end
        subsample = subsample_t'($urandom);
    endtask

    task automatic idle_levels;
        level_check("sample_valid", sample_valid, 1'b0);
        level_check("halt_n", halt_n, 1'b1);
    endtask

    // Captured triangle and colour must not follow the inputs
    task automatic held_outputs;
        for (int v = 0; v < `RASTER_VERTS; v++) begin
            for (int a = 0; a < `RASTER_AXIS; a++) begin
                coord_check($sformatf("tri_out[%0d][%0d]", v, a), tri_out[v][a],
                            exp_tri[v][a]);
            end
        end
        for (int c = 0; c < `RASTER_COLORS; c++) begin
            color_check($sformatf("color_out[%0d]", c), color_out[c], exp_color[c]);
        end
    endtask

    // Entered and left at a falling edge
    task automatic run_entry(input int i);
        int waited;
        int n;
        repeat (tab_gap[i]) begin
            idle_levels();
            tri_valid = 1'b0;
            @(negedge clk);
        end
        idle_levels();
        walk_order(i);
        box_in[0][0] = to_coord(tab_min_x[i]);
        box_in[0][1] = to_coord(tab_min_y[i]);
        box_in[1][0] = to_coord(tab_max_x[i]);
        box_in[1][1] = to_coord(tab_max_y[i]);
        subsample    = tab_code[i];
        fresh_inputs();
        exp_tri   = tri_in;
        exp_color = color_in;
        tri_valid = 1'b1;
        // Walk starts on the very next edge
        waited = 0;
        @(negedge clk);
        while (!sample_valid && waited < ACCEPT_WAIT) begin
            waited++;
            @(negedge clk);
        end
        if (!sample_valid) begin
            errors++;
            $display("entry %0d was never accepted, sample_valid stayed low", i);
        end else begin
            count_check("accept delay", waited, 0);
        end
        tri_valid = 1'b0;
        n = 0;
        while (sample_valid && n <= exp_x.size()) begin
            if (n < exp_x.size()) begin
                coord_check("sample[0]", sample[0], exp_x[n]);
                coord_check("sample[1]", sample[1], exp_y[n]);
            end
            level_check("halt_n", halt_n, 1'b0);
            held_outputs();
            n++;
            // New values under halt
            fresh_inputs();
            disturb_box();
            @(negedge clk);
        end
        count_check("valid cycles", n, exp_x.size());
        // Parked on lower-left after the walk
        coord_check("sample[0]", sample[0], to_coord(tab_min_x[i]));
        coord_check("sample[1]", sample[1], to_coord(tab_min_y[i]));
    endtask

    initial begin
        void'($urandom(32'h3ebe_1002));
        rst       = 1'b1;
        tri_valid = 1'b0;
        subsample = 4'b1000;
        box_in    = '{default: '0};
        tri_in    = '{default: '0};
        color_in  = '{default: '0};
        load_table();
        timeout_from_table();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            idle_levels();
        end
        rst = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(i);
        end
        idle_levels();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+.
source/raster_pkg.sv
source/sample_walker.sv
source/iter_control.sv
source/bbox_sample_iterator.sv
test/tb_bbox_sample_iterator.sv

//--- Makefile
# Verilator build and run of the sample iterator testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_bbox_sample_iterator
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Pass only when the run prints the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)
